// ==== logic/la_pkg.sv ====
`default_nettype none

package la_pkg;

    localparam int SAMPLES_PER_WORD = 8;
    localparam int BURST_MAX        = 16;
    localparam int FIFO_DEPTH       = 32;
    localparam int BUF_DEPTH        = 256;

    typedef logic [5:0]  sample_t;    // one probe sample
    typedef logic [63:0] word_t;      // byte lane k holds sample k, lane 0 earliest
    typedef logic [7:0]  addr_t;      // buffer address or word pointer
    typedef logic [4:0]  len_t;       // burst length, 0..16

    typedef enum logic [1:0] {
        TRIG_NONE,
        TRIG_RISE,
        TRIG_FALL,
        TRIG_HIGH
    } trig_type_e;

    typedef enum logic [1:0] {
        REG_CTRL,
        REG_TRIG,
        REG_DIV,
        REG_LEN
    } cfg_addr_e;

    typedef struct packed {
        cfg_addr_e   addr;
        logic [15:0] data;
    } cfg_wr_t;

    typedef struct packed {
        trig_type_e  trig_type;
        logic [2:0]  trig_chan;
        logic [7:0]  div;         // sample every div+1 cycles
        addr_t       words;       // capture length in words
    } cfg_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } buf_wr_t;

    typedef enum logic [1:0] {W_IDLE, W_BURST, W_COMMIT} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_BURST, R_DRAIN} rd_state_e;

endpackage

`default_nettype wire

// ==== logic/la_config_regs.sv ====
`default_nettype none

module la_config_regs (
    input  wire logic            clk_ip,
    input  wire logic            rst_n,
    input  wire logic            cfg_valid,
    output logic                 cfg_ready,
    input  wire la_pkg::cfg_wr_t cfg_wr,
    input  wire logic            busy,
    output la_pkg::cfg_t         cfg,
    output logic                 start
);
    import la_pkg::*;

    logic accept;

    // start covers the cycle before the writer raises busy
    assign cfg_ready = ~busy & ~start;
    assign accept    = cfg_valid & cfg_ready;

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            cfg   <= '0;
            start <= 1'b0;
        end else begin
            start <= accept & (cfg_wr.addr == REG_CTRL) & cfg_wr.data[0];   // one cycle pulse
            if (accept) begin
                case (cfg_wr.addr)
                    REG_TRIG: begin
                        cfg.trig_type <= trig_type_e'(cfg_wr.data[1:0]);
                        cfg.trig_chan <= cfg_wr.data[4:2];
                    end
                    REG_DIV: begin
                        cfg.div <= cfg_wr.data[7:0];
                    end
                    REG_LEN: begin
                        cfg.words <= addr_t'(cfg_wr.data[7:0]);
                    end
                    default: begin
                        // run bit only, decoded into start
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/la_capture.sv ====
`default_nettype none

module la_capture (
    input  wire logic            clk_ip,
    input  wire logic            rst_n,
    input  wire la_pkg::sample_t din,
    input  wire la_pkg::cfg_t    cfg,
    input  wire logic            start,
    output logic                 push,
    output la_pkg::word_t        push_word,
    output logic                 done
);
    import la_pkg::*;

    logic        active;      // capture in progress
    logic        trig_seen;
    logic [7:0]  div_cnt;
    logic [2:0]  lane;
    addr_t       word_cnt;
    sample_t     prev;        // last sample taken
    logic [55:0] pack;        // lanes 0..6 of the current word

    logic        live;
    logic        take;
    logic        cur_bit;
    logic        prv_bit;
    logic        hit;
    logic        store;
    logic [2:0]  lane_cur;
    addr_t       wc_cur;

    assign live     = start ? (cfg.words != '0) : active;
    assign take     = live & (start | (div_cnt == '0));
    assign cur_bit  = din[cfg.trig_chan];
    assign prv_bit  = start ? cur_bit : prev[cfg.trig_chan];   // first sample has no edge
    assign lane_cur = start ? '0 : lane;
    assign wc_cur   = start ? '0 : word_cnt;

    always_comb begin
        case (cfg.trig_type)
            TRIG_NONE: hit = 1'b1;
            TRIG_RISE: hit = cur_bit & ~prv_bit;
            TRIG_FALL: hit = ~cur_bit & prv_bit;
            default:   hit = cur_bit;
        endcase
    end

    assign store     = take & ((trig_seen & ~start) | hit);
    assign push      = store & (lane_cur == 3'(SAMPLES_PER_WORD - 1));
    assign push_word = {2'b00, din, pack};

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            trig_seen <= 1'b0;
            div_cnt   <= '0;
            lane      <= '0;
            word_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            if (start) begin
                active    <= (cfg.words != '0);
                trig_seen <= 1'b0;
                lane      <= '0;
                word_cnt  <= '0;
                done      <= (cfg.words == '0);    // zero length ends at once
            end
            if (take) begin
                div_cnt <= cfg.div;
            end else if (div_cnt != '0) begin
                div_cnt <= div_cnt - 1'b1;
            end
            if (store) begin
                trig_seen <= 1'b1;
                lane      <= lane_cur + 1'b1;
            end
            if (push) begin
                word_cnt <= wc_cur + 1'b1;
                if (wc_cur + 1'b1 == cfg.words) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_ip) begin
        if (take) begin
            prev <= din;
        end
        if (store) begin
            pack <= {2'b00, din, pack[55:8]};   // newest enters the top lane
        end
    end

endmodule

`default_nettype wire

// ==== logic/la_sync_fifo.sv ====
`default_nettype none

module la_sync_fifo (
    input  wire logic          clk_ip,
    input  wire logic          rst_n,
    input  wire logic          push,
    input  wire la_pkg::word_t push_word,
    input  wire logic          pop,
    output la_pkg::word_t      pop_word,
    output la_pkg::len_t       count,
    output logic               empty
);
    import la_pkg::*;

    word_t                         mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   fill;     // full depth count

    assign pop_word = mem[rd_ptr];           // head word visible before pop
    assign empty    = (fill == '0);
    assign count    = (fill >= BURST_MAX) ? len_t'(BURST_MAX) : len_t'(fill);

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    always_ff @(posedge clk_ip) begin
        if (push) begin
            mem[wr_ptr] <= push_word;
        end
    end

endmodule

`default_nettype wire

// ==== logic/la_burst_writer.sv ====
`default_nettype none

module la_burst_writer (
    input  wire logic          clk_ip,
    input  wire logic          rst_n,
    input  wire logic          start,
    input  wire logic          done,
    input  wire la_pkg::len_t  count,
    input  wire logic          empty,
    input  wire la_pkg::word_t pop_word,
    output logic               pop,
    output la_pkg::buf_wr_t    buf_wr,
    output la_pkg::addr_t      commit_ptr,
    output logic               busy
);
    import la_pkg::*;

    wr_state_e state;
    addr_t     wr_ptr;     // next buffer slot
    len_t      blen;       // size of current burst
    len_t      beats;      // words left in burst
    logic      go;

    // full burst ready, or the tail once capture has finished
    assign go = (count == len_t'(BURST_MAX)) | (done & ~empty);

    assign pop         = (state == W_BURST);
    assign buf_wr.en   = (state == W_BURST);
    assign buf_wr.addr = wr_ptr;
    assign buf_wr.data = pop_word;

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state      <= W_IDLE;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            blen       <= '0;
            beats      <= '0;
            busy       <= 1'b0;
        end else if (start) begin
            state      <= W_IDLE;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            busy       <= 1'b1;
        end else begin
            case (state)
                W_IDLE: begin
                    if (go) begin
                        blen  <= count;
                        beats <= count;
                        state <= W_BURST;
                    end else if (done & empty) begin
                        busy <= 1'b0;    // empty capture
                    end
                end
                W_BURST: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    beats  <= beats - 1'b1;
                    if (beats == len_t'(1)) begin
                        state <= W_COMMIT;
                    end
                end
                W_COMMIT: begin
                    commit_ptr <= commit_ptr + addr_t'(blen);
                    if (done & empty) begin
                        busy <= 1'b0;    // last word now committed
                    end
                    state <= W_IDLE;
                end
                default: begin
                    state <= W_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/la_sample_ram.sv ====
`default_nettype none

module la_sample_ram (
    input  wire logic            clk_ip,
    input  wire la_pkg::buf_wr_t buf_wr,
    input  wire la_pkg::addr_t   rd_addr,
    output la_pkg::word_t        rd_word
);
    import la_pkg::*;

    word_t mem [BUF_DEPTH];

    always_ff @(posedge clk_ip) begin
        if (buf_wr.en) begin
            mem[buf_wr.addr] <= buf_wr.data;
        end
    end

    // registered read, data one cycle after address
    always_ff @(posedge clk_ip) begin
        rd_word <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== logic/la_readback.sv ====
`default_nettype none

module la_readback (
    input  wire logic          clk_ip,
    input  wire logic          rst_n,
    input  wire logic          start,
    input  wire la_pkg::cfg_t  cfg,
    input  wire la_pkg::addr_t commit_ptr,
    output la_pkg::addr_t      rd_addr,
    input  wire la_pkg::word_t rd_word,
    output logic               out_valid,
    input  wire logic          out_ready,
    output la_pkg::word_t      out_data,
    output logic               out_last
);
    import la_pkg::*;

    rd_state_e state;
    addr_t     rd_ptr;       // next word to read
    addr_t     last_idx;     // word count latched at start
    len_t      beats;
    addr_t     avail;
    logic      out_free;
    logic      issue;
    logic      ret_valid;    // ram word arrives this cycle
    logic      ret_last;
    logic      skid_valid;
    logic      skid_last;
    word_t     skid_data;

    assign rd_addr  = rd_ptr;
    assign avail    = commit_ptr - rd_ptr;
    assign out_free = ~out_valid | out_ready;
    assign issue    = (state == R_BURST) & ~skid_valid & out_free;   // stall on back-pressure

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            state     <= R_IDLE;
            rd_ptr    <= '0;
            last_idx  <= '0;
            beats     <= '0;
            ret_valid <= 1'b0;
        end else if (start) begin
            state     <= R_IDLE;
            rd_ptr    <= '0;
            last_idx  <= cfg.words;
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= issue;
            case (state)
                R_IDLE: begin
                    if (commit_ptr > rd_ptr) begin
                        beats <= (avail >= addr_t'(BURST_MAX)) ? len_t'(BURST_MAX)
                                                               : len_t'(avail);
                        state <= R_BURST;
                    end
                end
                R_BURST: begin
                    if (issue) begin
                        rd_ptr <= rd_ptr + 1'b1;
                        beats  <= beats - 1'b1;
                        if (beats == len_t'(1)) begin
                            state <= R_DRAIN;
                        end
                    end
                end
                R_DRAIN: begin
                    if (~ret_valid & ~skid_valid) begin
                        state <= R_IDLE;
                    end
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_ip or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (start) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid | ret_valid;
            skid_valid <= 1'b0;
        end else if (ret_valid) begin
            skid_valid <= 1'b1;      // park returning word
        end
    end

    always_ff @(posedge clk_ip) begin
        ret_last <= (rd_ptr + 1'b1 == last_idx);
        if (out_free) begin
            out_data <= skid_valid ? skid_data : rd_word;
            out_last <= skid_valid ? skid_last : ret_last;
        end else if (ret_valid) begin
            skid_data <= rd_word;
            skid_last <= ret_last;
        end
    end

endmodule

`default_nettype wire

// ==== logic/la_top.sv ====
`default_nettype none

module la_top (
    input  wire logic            clk_ip,
    input  wire logic            rst_n,
    input  wire la_pkg::sample_t din,
    input  wire logic            cfg_valid,
    output logic                 cfg_ready,
    input  wire la_pkg::cfg_wr_t cfg_wr,
    output logic                 out_valid,
    input  wire logic            out_ready,
    output la_pkg::word_t        out_data,
    output logic                 out_last
);
    import la_pkg::*;

    cfg_t    cfg;
    logic    start;
    logic    busy;
    logic    push;
    word_t   push_word;
    logic    done;
    logic    pop;
    word_t   pop_word;
    len_t    count;
    logic    empty;
    buf_wr_t buf_wr;
    addr_t   commit_ptr;
    addr_t   rd_addr;
    word_t   rd_word;

    la_config_regs u_config_regs (
        .clk_ip    (clk_ip),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_wr    (cfg_wr),
        .busy      (busy),
        .cfg       (cfg),
        .start     (start)
    );

    la_capture u_capture (
        .clk_ip    (clk_ip),
        .rst_n     (rst_n),
        .din       (din),
        .cfg       (cfg),
        .start     (start),
        .push      (push),
        .push_word (push_word),
        .done      (done)
    );

    la_sync_fifo u_fifo (
        .clk_ip    (clk_ip),
        .rst_n     (rst_n),
        .push      (push),
        .push_word (push_word),
        .pop       (pop),
        .pop_word  (pop_word),
        .count     (count),
        .empty     (empty)
    );

    la_burst_writer u_writer (
        .clk_ip     (clk_ip),
        .rst_n      (rst_n),
        .start      (start),
        .done       (done),
        .count      (count),
        .empty      (empty),
        .pop_word   (pop_word),
        .pop        (pop),
        .buf_wr     (buf_wr),
        .commit_ptr (commit_ptr),
        .busy       (busy)
    );

    la_sample_ram u_ram (
        .clk_ip  (clk_ip),
        .buf_wr  (buf_wr),
        .rd_addr (rd_addr),
        .rd_word (rd_word)
    );

    la_readback u_readback (
        .clk_ip     (clk_ip),
        .rst_n      (rst_n),
        .start      (start),
        .cfg        (cfg),
        .commit_ptr (commit_ptr),
        .rd_addr    (rd_addr),
        .rd_word    (rd_word),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last)
    );

endmodule

`default_nettype wire

// ==== verif/la_tb.sv ====
`default_nettype none

module la_tb;
    import la_pkg::*;

    localparam int NUM_TESTS = 7;
    localparam int HIST_LEN  = 16384;

    typedef struct packed {
        trig_type_e trig;
        logic [2:0] chan;
        logic [7:0] div;
        logic [7:0] words;
        logic       rand_rdy;    // random out_ready
        logic       poke_busy;   // config write mid capture
    } test_t;

    test_t tests [NUM_TESTS] = '{
        '{TRIG_NONE, 3'd0, 8'd0, 8'd3,  1'b0, 1'b0},
        '{TRIG_RISE, 3'd2, 8'd3, 8'd5,  1'b0, 1'b0},
        '{TRIG_FALL, 3'd4, 8'd1, 8'd4,  1'b0, 1'b0},
        '{TRIG_HIGH, 3'd5, 8'd2, 8'd3,  1'b0, 1'b0},
        '{TRIG_NONE, 3'd0, 8'd1, 8'd40, 1'b0, 1'b0},
        '{TRIG_HIGH, 3'd3, 8'd0, 8'd20, 1'b1, 1'b0},
        '{TRIG_RISE, 3'd1, 8'd2, 8'd6,  1'b1, 1'b1}
    };

    string names [NUM_TESTS] = '{
        "trig_none_div0", "rise_ch2_div3", "fall_ch4_div1", "high_ch5_div2",
        "long_40_words", "ready_backpressure", "write_while_busy"
    };

    logic        clk_ip;
    logic        rst_n;
    sample_t     din;
    logic        cfg_valid;
    logic        cfg_ready;
    cfg_wr_t     cfg_wr;
    logic        out_valid;
    logic        out_ready;
    word_t       out_data;
    logic        out_last;

    logic [31:0] lcg_state;
    logic        rand_ready;
    int          cyc;
    sample_t     hist [HIST_LEN];    // din held in each cycle
    word_t       exp_words [BUF_DEPTH];
    word_t       got_words [BUF_DEPTH];
    logic        got_last [BUF_DEPTH];

    la_top u_dut (
        .clk_ip    (clk_ip),
        .rst_n     (rst_n),
        .din       (din),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_wr    (cfg_wr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int timeout_cycles();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            sum += (int'(tests[i].div) + 1) * SAMPLES_PER_WORD * int'(tests[i].words);
        end
        return 2 * sum + 400 * NUM_TESTS;    // trigger wait and readback margin
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run aborted");
    endtask

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic cfg_write(input cfg_addr_e addr, input logic [15:0] data,
                             output int acc_cyc);
        @(posedge clk_ip);
        cfg_valid   <= 1'b1;
        cfg_wr.addr <= addr;
        cfg_wr.data <= data;
        do begin
            @(negedge clk_ip);
        end while (!cfg_ready);
        acc_cyc = cyc;    // din set at the accepting edge is sample 0
        @(posedge clk_ip);
        cfg_valid <= 1'b0;
    endtask

    task automatic blocked_write(input string name);
        @(posedge clk_ip);
        cfg_valid   <= 1'b1;
        cfg_wr.addr <= REG_DIV;
        cfg_wr.data <= 16'h00a5;
        repeat (4) begin
            @(negedge clk_ip);
            compare($sformatf("%s cfg_ready", name), 64'd0, 64'(cfg_ready));
        end
        @(posedge clk_ip);
        cfg_valid <= 1'b0;
    endtask

    task automatic collect(input int words);
        int n;
        n = 0;
        while (n < words) begin
            @(negedge clk_ip);
            if (out_valid && out_ready) begin
                got_words[n] = out_data;
                got_last[n]  = out_last;
                n = n + 1;
            end
        end
    endtask

    // walk the sample instants, find the trigger, pack the words
    task automatic build_expected(input test_t t, input int start_cyc);
        int   step;
        int   k;
        int   idx;
        logic cur;
        logic prv;
        logic hit;
        step = int'(t.div) + 1;
        k    = 0;
        hit  = 1'b0;
        while (!hit) begin
            idx = start_cyc + k * step;
            if (idx >= cyc || idx >= HIST_LEN) begin
                abort_run("no trigger sample found in the recorded input");
            end
            cur = hist[idx][t.chan];
            prv = (k == 0) ? cur : hist[idx - step][t.chan];
            case (t.trig)
                TRIG_NONE: hit = 1'b1;
                TRIG_RISE: hit = cur & ~prv;
                TRIG_FALL: hit = ~cur & prv;
                default:   hit = cur;
            endcase
            if (!hit) begin
                k = k + 1;
            end
        end
        for (int w = 0; w < int'(t.words); w++) begin
            for (int j = 0; j < SAMPLES_PER_WORD; j++) begin
                idx = start_cyc + (k + w * SAMPLES_PER_WORD + j) * step;
                exp_words[w][j*8 +: 8] = {2'b00, hist[idx]};
            end
        end
    endtask

    initial begin
        clk_ip = 1'b0;
        forever #10 clk_ip = ~clk_ip;
    end

    initial begin
        lcg_state = 32'h47ec;
        cyc       = 0;
        din       <= '0;
        out_ready <= 1'b0;
        forever begin
            @(posedge clk_ip);
            lcg_state = lcg_next(lcg_state);
            din       <= lcg_state[21:16];
            out_ready <= rand_ready ? lcg_state[29] : 1'b1;
            if (cyc < HIST_LEN) begin
                hist[cyc] = lcg_state[21:16];
            end
            cyc = cyc + 1;
        end
    end

    initial begin
        int limit;
        limit = timeout_cycles();
        repeat (limit) @(posedge clk_ip);
        abort_run($sformatf("timeout, run not finished after %0d cycles", limit));
    end

    initial begin
        int    start_cyc;
        int    unused_cyc;
        test_t t;
        rand_ready  = 1'b0;
        rst_n     <= 1'b0;
        cfg_valid <= 1'b0;
        cfg_wr    <= '0;
        repeat (3) @(posedge clk_ip);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_TESTS; i++) begin
            t = tests[i];
            @(negedge clk_ip);
            rand_ready = t.rand_rdy;
            cfg_write(REG_TRIG, {11'd0, t.chan, t.trig}, unused_cyc);
            cfg_write(REG_DIV, {8'd0, t.div}, unused_cyc);
            cfg_write(REG_LEN, {8'd0, t.words}, unused_cyc);
            cfg_write(REG_CTRL, 16'd1, start_cyc);
            if (t.poke_busy) begin
                blocked_write(names[i]);
            end
            collect(int'(t.words));
            build_expected(t, start_cyc);
            for (int w = 0; w < int'(t.words); w++) begin
                compare($sformatf("%s word %0d", names[i], w), exp_words[w], got_words[w]);
                compare($sformatf("%s last %0d", names[i], w),
                        64'(w == int'(t.words) - 1), 64'(got_last[w]));
            end
            repeat (4) begin    // nothing extra after the last word
                @(negedge clk_ip);
                compare($sformatf("%s idle", names[i]), 64'd0, 64'(out_valid));
            end
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== la.f ====
logic/la_pkg.sv
logic/la_config_regs.sv
logic/la_capture.sv
logic/la_sync_fifo.sv
logic/la_burst_writer.sv
logic/la_sample_ram.sv
logic/la_readback.sv
logic/la_top.sv
verif/la_tb.sv

// ==== Makefile ====
TOP := la_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): la.f $(wildcard logic/*.sv) verif/la_tb.sv
	verilator --binary --timing -j 0 --top-module $(TOP) -f la.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
